// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module pipelineCore

sim:
	verilator --binary --timing -f sim.f --top-module coreTb -Mdir obj_dir -o coreSim
	./obj_dir/coreSim > sim.log 2>&1 || true
	cat sim.log
	grep -qx "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/coreTb.sv ====
module coreTb;

    localparam int progLen = 33;
    localparam int numExp  = 23;

    logic        clk;
    logic        rst;
    logic [31:0] imemData;
    logic [31:0] imemAddr;
    logic        wbWe;
    logic [4:0]  wbReg;
    logic [31:0] wbData;
    logic [31:0] wbPc;

    logic [31:0] progMem   [progLen];
    logic [4:0]  expRegTab [numExp];
    logic [31:0] expValTab [numExp];
    logic [31:0] expPcTab  [numExp];
    logic [4:0]  expReg;
    logic [31:0] expVal;
    logic [31:0] expPc;
    logic [31:0] wordIdx;
    int          entry;
    int          errors;
    int          fillIdx;
    int          cycles;
    logic        timedOut;

    pipelineCore UUT (
        .clk(clk), .rst(rst), .imemData(imemData), .imemAddr(imemAddr),
        .wbWe(wbWe), .wbReg(wbReg), .wbData(wbData), .wbPc(wbPc)
    );

    retireChecker #(.numExp(numExp)) retireMon (
        .clk(clk), .wbWe(wbWe), .wbReg(wbReg), .wbData(wbData), .wbPc(wbPc),
        .expReg(expReg), .expVal(expVal), .expPc(expPc), .entry(entry), .errors(errors)
    );

    assign expReg = (entry < numExp) ? expRegTab[entry[4:0]] : 5'd0;
    assign expVal = (entry < numExp) ? expValTab[entry[4:0]] : 32'd0;
    assign expPc  = (entry < numExp) ? expPcTab[entry[4:0]] : 32'd0;

    //////////////////////////////////////////////////////////////////////
    // Instruction encoding
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] rWord(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] funct);
        return {corePkg::opSpecial, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jWord(input logic [25:0] index);
        return {corePkg::opJ, index};
    endfunction

    task automatic addRetire(input logic [4:0] r, input logic [31:0] v, input logic [31:0] pc);
        expRegTab[fillIdx[4:0]] = r;
        expValTab[fillIdx[4:0]] = v;
        expPcTab[fillIdx[4:0]]  = pc;
        fillIdx++;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Addresses past the table read as a no-op
    initial begin
        imemData = 32'd0;
        forever begin
            @(negedge clk);
            wordIdx  = {2'b00, imemAddr[31:2]};
            imemData = (wordIdx < progLen) ? progMem[wordIdx[5:0]] : 32'd0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Program and expected retires
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst      = 1'b1;
        timedOut = 1'b0;
        progMem[0]  = iWord(corePkg::opOri, 5'd0, 5'd1, 16'h1234);
        progMem[1]  = iWord(corePkg::opLui, 5'd0, 5'd2, 16'hABCD);
        progMem[2]  = iWord(corePkg::opOri, 5'd0, 5'd3, 16'h0005);
        progMem[3]  = iWord(corePkg::opOri, 5'd0, 5'd4, 16'h0007);
        progMem[4]  = rWord(5'd1, 5'd2, 5'd5, corePkg::fnAddu);
        progMem[5]  = rWord(5'd3, 5'd4, 5'd6, corePkg::fnSubu);
        // Distance one and two
        progMem[6]  = rWord(5'd5, 5'd6, 5'd7, corePkg::fnAddu);
        progMem[7]  = rWord(5'd7, 5'd1, 5'd8, corePkg::fnSubu);
        progMem[8]  = iWord(corePkg::opOri, 5'd0, 5'd9, 16'h0010);
        progMem[9]  = iWord(corePkg::opSw, 5'd9, 5'd8, 16'h0000);
        progMem[10] = iWord(corePkg::opLw, 5'd9, 5'd10, 16'h0000);
        // Load-use
        progMem[11] = rWord(5'd10, 5'd3, 5'd11, corePkg::fnAddu);
        progMem[12] = iWord(corePkg::opOri, 5'd0, 5'd12, 16'h5A5A);
        progMem[13] = iWord(corePkg::opSw, 5'd9, 5'd12, 16'h0004);
        progMem[14] = iWord(corePkg::opLw, 5'd9, 5'd13, 16'h0004);
        // Store of a word still being loaded
        progMem[15] = iWord(corePkg::opLw, 5'd9, 5'd14, 16'h0000);
        progMem[16] = iWord(corePkg::opSw, 5'd9, 5'd14, 16'h0008);
        progMem[17] = iWord(corePkg::opLw, 5'd9, 5'd15, 16'h0008);
        // Not taken, then taken on a forwarded operand
        progMem[18] = iWord(corePkg::opBeq, 5'd3, 5'd4, 16'h0004);
        progMem[19] = iWord(corePkg::opOri, 5'd0, 5'd16, 16'h0001);
        progMem[20] = iWord(corePkg::opOri, 5'd0, 5'd17, 16'h0002);
        progMem[21] = iWord(corePkg::opOri, 5'd0, 5'd18, 16'h0005);
        progMem[22] = iWord(corePkg::opBeq, 5'd18, 5'd3, 16'h0002);
        progMem[23] = iWord(corePkg::opOri, 5'd0, 5'd19, 16'h0003);
        progMem[24] = iWord(corePkg::opOri, 5'd0, 5'd20, 16'hDEAD);
        progMem[25] = jWord(26'd28);
        progMem[26] = iWord(corePkg::opOri, 5'd0, 5'd21, 16'h0004);
        progMem[27] = iWord(corePkg::opOri, 5'd0, 5'd22, 16'hBEEF);
        progMem[28] = iWord(corePkg::opOri, 5'd0, 5'd23, 16'h0006);
        // Register 0 as destination and as source
        progMem[29] = iWord(corePkg::opOri, 5'd0, 5'd0, 16'h7777);
        progMem[30] = rWord(5'd1, 5'd2, 5'd0, corePkg::fnAddu);
        progMem[31] = rWord(5'd0, 5'd3, 5'd24, corePkg::fnAddu);
        progMem[32] = rWord(5'd0, 5'd3, 5'd25, corePkg::fnSubu);

        fillIdx = 0;
        addRetire(5'd1, 32'h0000_1234, 32'h00);
        addRetire(5'd2, 32'hABCD_0000, 32'h04);
        addRetire(5'd3, 32'h0000_0005, 32'h08);
        addRetire(5'd4, 32'h0000_0007, 32'h0C);
        addRetire(5'd5, 32'hABCD_1234, 32'h10);
        addRetire(5'd6, 32'hFFFF_FFFE, 32'h14);
        addRetire(5'd7, 32'hABCD_1232, 32'h18);
        addRetire(5'd8, 32'hABCC_FFFE, 32'h1C);
        addRetire(5'd9, 32'h0000_0010, 32'h20);
        addRetire(5'd10, 32'hABCC_FFFE, 32'h28);
        addRetire(5'd11, 32'hABCD_0003, 32'h2C);
        addRetire(5'd12, 32'h0000_5A5A, 32'h30);
        addRetire(5'd13, 32'h0000_5A5A, 32'h38);
        addRetire(5'd14, 32'hABCC_FFFE, 32'h3C);
        addRetire(5'd15, 32'hABCC_FFFE, 32'h44);
        addRetire(5'd16, 32'h0000_0001, 32'h4C);
        addRetire(5'd17, 32'h0000_0002, 32'h50);
        addRetire(5'd18, 32'h0000_0005, 32'h54);
        addRetire(5'd19, 32'h0000_0003, 32'h5C);
        addRetire(5'd21, 32'h0000_0004, 32'h68);
        addRetire(5'd23, 32'h0000_0006, 32'h70);
        addRetire(5'd24, 32'h0000_0005, 32'h7C);
        addRetire(5'd25, 32'hFFFF_FFFB, 32'h80);

        repeat (5) @(negedge clk);
        rst = 1'b0;

        for (cycles = 0; cycles < 2000 && entry < numExp; cycles++) begin
            @(negedge clk);
        end
        if (entry < numExp) begin
            timedOut = 1'b1;
            $display("Timeout: only %0d of %0d expected writes retired in 2000 cycles",
                     entry, numExp);
        end

        // A few more cycles to catch stray writes
        for (cycles = 0; cycles < 10; cycles++) begin
            @(negedge clk);
        end

        $display("Summary: %0d of %0d retires seen, %0d errors", entry, numExp, errors);
        if (timedOut || errors != 0) begin
            $display("FAIL: see errors above");
        end else begin
            $display("PASS: all tests");
        end
        $finish;
    end

endmodule

// ==== bench/retireChecker.sv ====
module retireChecker #(
    parameter int numExp = 1
) (
    input  logic        clk,
    input  logic        wbWe,
    input  logic [4:0]  wbReg,
    input  logic [31:0] wbData,
    input  logic [31:0] wbPc,
    input  logic [4:0]  expReg,
    input  logic [31:0] expVal,
    input  logic [31:0] expPc,
    output int          entry,
    output int          errors
);

    int seen = 0;
    int bad  = 0;
    int miss;

    assign entry  = seen;
    assign errors = bad;

    // Retire ports change on the rising edge, so look at them halfway through
    always @(negedge clk) begin
        if (wbWe !== 1'b0 && wbWe !== 1'b1) begin
            $display("%0t: write enable wbWe is unknown", $time);
            bad <= bad + 1;
        end else if (wbWe) begin
            if (seen >= numExp) begin
                $display("%0t: unexpected register write to r%0d, data %h, pc %h",
                         $time, wbReg, wbData, wbPc);
                bad <= bad + 1;
            end else begin
                miss = 0;
                if (wbReg !== expReg) begin
                    $display("CHECK FAILED t=%0t wbReg: expected %0d, got %0d",
                             $time, expReg, wbReg);
                    miss++;
                end
                if (wbData !== expVal) begin
                    $display("CHECK FAILED t=%0t wbData: expected %h, got %h",
                             $time, expVal, wbData);
                    miss++;
                end
                if (wbPc !== expPc) begin
                    $display("CHECK FAILED t=%0t wbPc: expected %h, got %h",
                             $time, expPc, wbPc);
                    miss++;
                end
                $display("retire %0d: r%0d = %h at pc %h %s", seen, expReg, expVal, expPc,
                         (miss == 0) ? "ok" : "wrong");
                bad  <= bad + miss;
                seen <= seen + 1;
            end
        end
    end

endmodule

// ==== logic/corePkg.sv ====
package corePkg;

    //////////////////////////////////////////////////////////////////////
    // Opcodes and function codes
    //////////////////////////////////////////////////////////////////////

    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;

    // Operand source select
    localparam logic [1:0] fwdNone = 2'd0;
    localparam logic [1:0] fwdMem  = 2'd1;
    localparam logic [1:0] fwdWb   = 2'd2;

    localparam int dmemWords    = 64;
    localparam int dmemAddrBits = $clog2(dmemWords);

    //////////////////////////////////////////////////////////////////////
    // Instruction word views
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormatT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFormatT;

    typedef union packed {
        rFormatT r;
        iFormatT i;
    } instrT;

    // Same operand mux in the comparator and in front of the ALU
    function automatic logic [31:0] fwdMux(
        input logic [1:0]  sel,
        input logic [31:0] regVal,
        input logic [31:0] memVal,
        input logic [31:0] wbVal
    );
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

endpackage

// ==== logic/decodeStage.sv ====
module decodeStage (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  corePkg::instrT instrD,
    input  logic [31:0]    pcPlus4D,
    input  logic           wbWe,
    input  logic [4:0]     wbReg,
    input  logic [31:0]    wbData,
    input  logic [31:0]    aluM,
    input  logic [1:0]     cmpASel,
    input  logic [1:0]     cmpBSel,
    output logic           redirect,
    output logic [31:0]    target,
    output corePkg::instrT instrE,
    output logic [31:0]    aE,
    output logic [31:0]    bE,
    output logic [31:0]    immE,
    output logic [4:0]     destE,
    output logic [31:0]    pcE
);

    logic [31:0] regFile [32];
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [31:0] rdA;
    logic [31:0] rdB;
    logic [31:0] cmpA;
    logic [31:0] cmpB;
    logic [31:0] imm;
    logic [31:0] branchOff;
    logic [4:0]  dest;
    logic        isBeq;
    logic        isJ;

    assign rs = instrD.r.rs;
    assign rt = instrD.r.rt;

    //////////////////////////////////////////////////////////////////////
    // Register file with write-first read
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wbWe) begin
            regFile[wbReg] <= wbData;
        end
    end

    assign rdA = (rs == 5'd0) ? '0 : (wbWe && wbReg == rs) ? wbData : regFile[rs];
    assign rdB = (rt == 5'd0) ? '0 : (wbWe && wbReg == rt) ? wbData : regFile[rt];

    //////////////////////////////////////////////////////////////////////
    // Branch and jump resolution
    //////////////////////////////////////////////////////////////////////

    assign cmpA = corePkg::fwdMux(cmpASel, rdA, aluM, wbData);
    assign cmpB = corePkg::fwdMux(cmpBSel, rdB, aluM, wbData);

    assign isBeq     = instrD.i.opcode == corePkg::opBeq;
    assign isJ       = instrD.i.opcode == corePkg::opJ;
    assign branchOff = {{14{instrD.i.imm16[15]}}, instrD.i.imm16, 2'b00};

    // Jump index is everything below the opcode
    assign target = isJ ? {pcPlus4D[31:28], instrD.i.rs, instrD.i.rt, instrD.i.imm16, 2'b00}
                        : pcPlus4D + branchOff;
    assign redirect = !stall && (isJ || (isBeq && cmpA == cmpB));

    always_comb begin
        case (instrD.i.opcode)
            corePkg::opOri: imm = {16'h0000, instrD.i.imm16};
            corePkg::opLui: imm = {instrD.i.imm16, 16'h0000};
            default:        imm = {{16{instrD.i.imm16[15]}}, instrD.i.imm16};
        endcase
    end

    // rd for R-format, rt for I-format writers, none otherwise
    always_comb begin
        case (instrD.i.opcode)
            corePkg::opSpecial: begin
                if (instrD.r.funct == corePkg::fnAddu || instrD.r.funct == corePkg::fnSubu) begin
                    dest = instrD.r.rd;
                end else begin
                    dest = 5'd0;
                end
            end
            corePkg::opOri, corePkg::opLui, corePkg::opLw: dest = rt;
            default: dest = 5'd0;
        endcase
    end

    // ID/EX
    always_ff @(posedge clk) begin
        if (rst || stall) begin
            instrE <= '0;
            destE  <= '0;
        end else begin
            instrE <= instrD;
            destE  <= dest;
        end
    end

    always_ff @(posedge clk) begin
        aE   <= rdA;
        bE   <= rdB;
        immE <= imm;
        pcE  <= pcPlus4D - 32'd4;
    end

endmodule

// ==== logic/executeStage.sv ====
module executeStage (
    input  logic           clk,
    input  logic           rst,
    input  corePkg::instrT instrE,
    input  logic [31:0]    aE,
    input  logic [31:0]    bE,
    input  logic [31:0]    immE,
    input  logic [4:0]     destE,
    input  logic [31:0]    pcE,
    input  logic [31:0]    wbData,
    input  logic [1:0]     aluASel,
    input  logic [1:0]     aluBSel,
    output corePkg::instrT instrM,
    output logic [31:0]    aluM,
    output logic [31:0]    storeM,
    output logic [4:0]     destM,
    output logic [31:0]    pcM
);

    logic [31:0] opA;
    logic [31:0] fwdB;
    logic [31:0] opB;
    logic [31:0] aluOut;

    assign opA  = corePkg::fwdMux(aluASel, aE, aluM, wbData);
    assign fwdB = corePkg::fwdMux(aluBSel, bE, aluM, wbData);
    assign opB  = (instrE.r.opcode == corePkg::opSpecial) ? fwdB : immE;

    always_comb begin
        case (instrE.r.opcode)
            corePkg::opSpecial: begin
                case (instrE.r.funct)
                    corePkg::fnAddu: aluOut = opA + opB;
                    corePkg::fnSubu: aluOut = opA - opB;
                    default:         aluOut = '0;
                endcase
            end
            corePkg::opOri:              aluOut = opA | opB;
            // Immediate arrives already shifted
            corePkg::opLui:              aluOut = opB;
            corePkg::opLw, corePkg::opSw: aluOut = opA + opB;
            default:                     aluOut = '0;
        endcase
    end

    // EX/MEM
    always_ff @(posedge clk) begin
        if (rst) begin
            instrM <= '0;
            destM  <= '0;
        end else begin
            instrM <= instrE;
            destM  <= destE;
        end
    end

    always_ff @(posedge clk) begin
        aluM   <= aluOut;
        storeM <= fwdB;
        pcM    <= pcE;
    end

endmodule

// ==== logic/fetchStage.sv ====
module fetchStage (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           redirect,
    input  logic [31:0]    target,
    input  logic [31:0]    imemData,
    output logic [31:0]    imemAddr,
    output corePkg::instrT instrD,
    output logic [31:0]    pcPlus4D
);

    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] pcNext;

    assign imemAddr = pc;
    assign pcPlus4  = pc + 32'd4;

    // Hold wins over a redirect; decode re-issues it after the stall
    always_comb begin
        if (stall) begin
            pcNext = pc;
        end else if (redirect) begin
            pcNext = target;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // IF/ID
    always_ff @(posedge clk) begin
        if (rst) begin
            instrD <= '0;
        end else if (!stall) begin
            instrD <= imemData;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pcPlus4D <= pcPlus4;
        end
    end

endmodule

// ==== logic/hazardUnit.sv ====
module hazardUnit (
    input  corePkg::instrT instrD,
    input  corePkg::instrT instrE,
    input  logic [4:0]     destE,
    input  logic [4:0]     destM,
    input  logic [4:0]     wbReg,
    input  logic           wbWe,
    input  logic           loadInE,
    input  logic           loadInM,
    output logic           stall,
    output logic [1:0]     cmpASel,
    output logic [1:0]     cmpBSel,
    output logic [1:0]     aluASel,
    output logic [1:0]     aluBSel
);

    logic [4:0] rsD;
    logic [4:0] rtD;
    logic       useRsD;
    logic       useRtD;
    logic       isBeqD;
    logic       hitE;
    logic       hitM;
    logic       loadUse;
    logic       branchWait;

    function automatic logic [1:0] pickSrc(input logic [4:0] src, input logic [4:0] memDest,
                                           input logic [4:0] wbDest, input logic wbValid);
        if (src != 5'd0 && src == memDest) begin
            return corePkg::fwdMem;
        end else if (wbValid && src == wbDest) begin
            return corePkg::fwdWb;
        end
        return corePkg::fwdNone;
    endfunction

    assign rsD    = instrD.r.rs;
    assign rtD    = instrD.r.rt;
    assign isBeqD = instrD.i.opcode == corePkg::opBeq;

    // sw data in rt is caught later by store forwarding
    assign useRsD = instrD.i.opcode inside {corePkg::opSpecial, corePkg::opOri,
                                            corePkg::opLw, corePkg::opSw, corePkg::opBeq};
    assign useRtD = instrD.i.opcode inside {corePkg::opSpecial, corePkg::opBeq};

    assign hitE = destE != 5'd0 && ((useRsD && rsD == destE) || (useRtD && rtD == destE));
    assign hitM = destM != 5'd0 && (rsD == destM || rtD == destM);

    assign loadUse    = loadInE && hitE;
    assign branchWait = isBeqD && (hitE || (loadInM && hitM));
    assign stall      = loadUse || branchWait;

    assign cmpASel = pickSrc(rsD, destM, wbReg, wbWe);
    assign cmpBSel = pickSrc(rtD, destM, wbReg, wbWe);
    assign aluASel = pickSrc(instrE.r.rs, destM, wbReg, wbWe);
    assign aluBSel = pickSrc(instrE.r.rt, destM, wbReg, wbWe);

endmodule

// ==== logic/memoryStage.sv ====
module memoryStage (
    input  logic           clk,
    input  logic           rst,
    input  corePkg::instrT instrM,
    input  logic [31:0]    aluM,
    input  logic [31:0]    storeM,
    input  logic [4:0]     destM,
    input  logic [31:0]    pcM,
    output logic           wbWe,
    output logic [4:0]     wbReg,
    output logic [31:0]    wbData,
    output logic [31:0]    wbPc
);

    logic [31:0]                     dmem [corePkg::dmemWords];
    logic [corePkg::dmemAddrBits-1:0] wordAddr;
    logic [31:0]                     storeData;
    logic                            isLw;
    logic                            isSw;

    assign wordAddr = aluM[corePkg::dmemAddrBits+1:2];
    assign isLw     = instrM.i.opcode == corePkg::opLw;
    assign isSw     = instrM.i.opcode == corePkg::opSw;

    // A load just ahead of the store may still be retiring
    assign storeData = (wbWe && wbReg == instrM.i.rt) ? wbData : storeM;

    always_ff @(posedge clk) begin
        if (isSw) begin
            dmem[wordAddr] <= storeData;
        end
    end

    // MEM/WB
    always_ff @(posedge clk) begin
        if (rst) begin
            wbWe  <= 1'b0;
            wbReg <= '0;
        end else begin
            wbWe  <= destM != 5'd0;
            wbReg <= destM;
        end
    end

    always_ff @(posedge clk) begin
        wbData <= isLw ? dmem[wordAddr] : aluM;
        wbPc   <= pcM;
    end

endmodule

// ==== logic/pipelineCore.sv ====
module pipelineCore (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] imemData,
    output logic [31:0] imemAddr,
    output logic        wbWe,
    output logic [4:0]  wbReg,
    output logic [31:0] wbData,
    output logic [31:0] wbPc
);

    corePkg::instrT instrD;
    corePkg::instrT instrE;
    corePkg::instrT instrM;
    logic [31:0]    pcPlus4D;
    logic [31:0]    target;
    logic           redirect;
    logic           stall;
    logic [31:0]    aE;
    logic [31:0]    bE;
    logic [31:0]    immE;
    logic [4:0]     destE;
    logic [31:0]    pcE;
    logic [31:0]    aluM;
    logic [31:0]    storeM;
    logic [4:0]     destM;
    logic [31:0]    pcM;
    logic [1:0]     cmpASel;
    logic [1:0]     cmpBSel;
    logic [1:0]     aluASel;
    logic [1:0]     aluBSel;
    logic           loadInE;
    logic           loadInM;

    assign loadInE = instrE.i.opcode == corePkg::opLw;
    assign loadInM = instrM.i.opcode == corePkg::opLw;

    fetchStage fetch (
        .clk(clk), .rst(rst), .stall(stall), .redirect(redirect), .target(target),
        .imemData(imemData), .imemAddr(imemAddr), .instrD(instrD), .pcPlus4D(pcPlus4D)
    );

    decodeStage decode (
        .clk(clk), .rst(rst), .stall(stall), .instrD(instrD), .pcPlus4D(pcPlus4D),
        .wbWe(wbWe), .wbReg(wbReg), .wbData(wbData), .aluM(aluM),
        .cmpASel(cmpASel), .cmpBSel(cmpBSel), .redirect(redirect), .target(target),
        .instrE(instrE), .aE(aE), .bE(bE), .immE(immE), .destE(destE), .pcE(pcE)
    );

    executeStage execute (
        .clk(clk), .rst(rst), .instrE(instrE), .aE(aE), .bE(bE), .immE(immE),
        .destE(destE), .pcE(pcE), .wbData(wbData), .aluASel(aluASel), .aluBSel(aluBSel),
        .instrM(instrM), .aluM(aluM), .storeM(storeM), .destM(destM), .pcM(pcM)
    );

    memoryStage memory (
        .clk(clk), .rst(rst), .instrM(instrM), .aluM(aluM), .storeM(storeM),
        .destM(destM), .pcM(pcM), .wbWe(wbWe), .wbReg(wbReg), .wbData(wbData), .wbPc(wbPc)
    );

    hazardUnit hazard (
        .instrD(instrD), .instrE(instrE), .destE(destE), .destM(destM),
        .wbReg(wbReg), .wbWe(wbWe), .loadInE(loadInE), .loadInM(loadInM),
        .stall(stall), .cmpASel(cmpASel), .cmpBSel(cmpBSel),
        .aluASel(aluASel), .aluBSel(aluBSel)
    );

endmodule

// ==== sim.f ====
logic/corePkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/hazardUnit.sv
logic/pipelineCore.sv
bench/retireChecker.sv
bench/coreTb.sv
